// ==== src/dispPkg.sv ====
package dispPkg;

    // --------------------
    // 640x480 line timing, in pixel clocks
    // --------------------
    localparam int hDisplay = 640;
    localparam int hFront   = 16;
    localparam int hSync    = 96;
    localparam int hBack    = 48;
    localparam int hTotal   = 800;

    // frame timing, in lines
    localparam int vDisplay = 480;
    localparam int vBottom  = 11;
    localparam int vSync    = 2;
    localparam int vTop     = 31;
    localparam int vTotal   = 524;

    // position counter widths
    localparam int hCountW  = 10;
    localparam int vCountW  = 10;

    // negative sync for this mode
    localparam logic syncActive = 1'b0;

    // --------------------
    // phase codes shared by both timing FSMs
    // --------------------
    localparam logic [1:0] phDisplay = 2'd0;
    localparam logic [1:0] phFront   = 2'd1;
    localparam logic [1:0] phSync    = 2'd2;
    localparam logic [1:0] phBack    = 2'd3;

    // TMDS control tokens, index is {c1, c0}
    localparam logic [9:0] ctrlTok00 = 10'b1101010100;
    localparam logic [9:0] ctrlTok01 = 10'b0010101011;
    localparam logic [9:0] ctrlTok10 = 10'b0101010100;
    localparam logic [9:0] ctrlTok11 = 10'b1010101011;

    // test pattern select
    localparam logic patBars     = 1'b0;
    localparam logic patGradient = 1'b1;
    localparam int   barWidth    = 80;

    // one pixel, seen as named colours or as TMDS channel bytes
    // ch[0] blue, ch[1] green, ch[2] red
    typedef union packed {
        struct packed {
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
        } rgb;
        logic [2:0][7:0] ch;
    } pixel_u;

endpackage

// ==== src/dispCounter.sv ====
`timescale 1ns/1ps

module dispCounter (
    input  logic                        pixelClk,
    input  logic                        arstN,
    output logic [dispPkg::hCountW-1:0] hCount,
    output logic [dispPkg::vCountW-1:0] vCount,
    output logic                        lineEnd,
    output logic                        frameEnd
);

    import dispPkg::*;

    // --------------------
    // end of line / frame
    // --------------------

    // last pixel clock of the line
    assign lineEnd  = (hCount == hCountW'(hTotal - 1));

    // last pixel clock of the last line
    assign frameEnd = lineEnd && (vCount == vCountW'(vTotal - 1));

    // --------------------
    // horizontal position
    // --------------------
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
        end else if (lineEnd) begin
            // wrap back to first pixel
            hCount <= '0;
        end else begin
            hCount <= hCount + hCountW'(1);
        end
    end

    // --------------------
    // vertical position
    // --------------------
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            vCount <= '0;
        end else if (frameEnd) begin
            // wrap to line 0 after the top porch
            vCount <= '0;
        end else if (lineEnd) begin
            // one step per full line
            vCount <= vCount + vCountW'(1);
        end
    end

endmodule

// ==== src/dispTimingFsm.sv ====
`timescale 1ns/1ps

module dispTimingFsm (
    input  logic                        pixelClk,
    input  logic                        arstN,
    input  logic [dispPkg::hCountW-1:0] hCount,
    input  logic [dispPkg::vCountW-1:0] vCount,
    input  logic                        lineEnd,
    input  logic                        frameEnd,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        de,
    output logic                        frameStart,
    output logic [dispPkg::hCountW-1:0] xPos,
    output logic [dispPkg::vCountW-1:0] yPos
);

    import dispPkg::*;

    // phase of the current hCount / vCount
    logic [1:0] hState;
    logic [1:0] vState;

    // --------------------
    // horizontal FSM
    // --------------------
    // state moves on the last count of each phase,
    // so hState always matches hCount
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            hState <= phDisplay;
        end else begin
            case (hState)
                phDisplay: if (hCount == hCountW'(hDisplay - 1)) hState <= phFront;
                phFront:   if (hCount == hCountW'(hDisplay + hFront - 1)) hState <= phSync;
                phSync: begin
                    if (hCount == hCountW'(hDisplay + hFront + hSync - 1)) begin
                        hState <= phBack;
                    end
                end
                default:   if (lineEnd) hState <= phDisplay;
            endcase
        end
    end

    // --------------------
    // vertical FSM
    // --------------------
    // only steps at line end, looking at the line about to finish
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            vState <= phDisplay;
        end else if (lineEnd) begin
            case (vState)
                phDisplay: if (vCount == vCountW'(vDisplay - 1)) vState <= phFront;
                phFront:   if (vCount == vCountW'(vDisplay + vBottom - 1)) vState <= phSync;
                phSync: begin
                    if (vCount == vCountW'(vDisplay + vBottom + vSync - 1)) begin
                        vState <= phBack;
                    end
                end
                // top porch ends with the frame
                default:   if (frameEnd) vState <= phDisplay;
            endcase
        end
    end

    // --------------------
    // registered outputs
    // --------------------
    // one clock behind the counters
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            hsync      <= ~syncActive;
            vsync      <= ~syncActive;
            de         <= 1'b0;
            frameStart <= 1'b0;
            xPos       <= '0;
            yPos       <= '0;
        end else begin
            hsync      <= (hState == phSync) ? syncActive : ~syncActive;
            vsync      <= (vState == phSync) ? syncActive : ~syncActive;
            de         <= (hState == phDisplay) && (vState == phDisplay);
            // first active pixel of the frame
            frameStart <= (hCount == '0) && (vCount == '0);
            // active area starts at count 0, so counts are the coordinates
            xPos       <= (hState == phDisplay) ? hCount : '0;
            yPos       <= (vState == phDisplay) ? vCount : '0;
        end
    end

endmodule

// ==== src/pixelPattern.sv ====
`timescale 1ns/1ps

module pixelPattern (
    input  logic                        pixelClk,
    input  logic                        arstN,
    input  logic                        patternSel,
    input  logic                        hsync,
    input  logic                        vsync,
    input  logic                        de,
    input  logic                        frameStart,
    input  logic [dispPkg::hCountW-1:0] xPos,
    input  logic [dispPkg::vCountW-1:0] yPos,
    output dispPkg::pixel_u             pixel,
    output logic                        pDe,
    output logic                        pHsync,
    output logic                        pVsync
);

    import dispPkg::*;

    logic                patQ;
    logic                patCur;
    logic [hCountW-1:0]  barQuot;
    logic [2:0]          barIdx;
    pixel_u              pixelNext;

    // --------------------
    // pattern select
    // --------------------
    // new choice takes effect on the frame's first pixel
    assign patCur = frameStart ? patternSel : patQ;

    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            patQ <= patBars;
        end else if (frameStart) begin
            patQ <= patternSel;
        end
    end

    // bar number 0..7 across the line
    assign barQuot = xPos / hCountW'(barWidth);
    assign barIdx  = barQuot[2:0];

    // --------------------
    // colour generation
    // --------------------
    always_comb begin
        pixelNext = '0;
        if (de) begin
            if (patCur == patGradient) begin
                pixelNext.rgb.red   = xPos[7:0];
                pixelNext.rgb.green = yPos[7:0];
                // wraps mod 256
                pixelNext.rgb.blue  = xPos[7:0] + yPos[7:0];
            end else begin
                // white yellow cyan green magenta red blue black
                pixelNext.rgb.red   = {8{~barIdx[1]}};
                pixelNext.rgb.green = {8{~barIdx[2]}};
                pixelNext.rgb.blue  = {8{~barIdx[0]}};
            end
        end
    end

    // registered pixel word
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            pixel <= '0;
        end else begin
            pixel <= pixelNext;
        end
    end

    // controls delayed to stay aligned with the pixel
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            pDe    <= 1'b0;
            pHsync <= ~syncActive;
            pVsync <= ~syncActive;
        end else begin
            pDe    <= de;
            pHsync <= hsync;
            pVsync <= vsync;
        end
    end

endmodule

// ==== src/tmdsEncoder.sv ====
`timescale 1ns/1ps

module tmdsEncoder (
    input  logic       pixelClk,
    input  logic       arstN,
    input  logic       de,
    input  logic [1:0] ctrl,
    input  logic [7:0] data,
    output logic [9:0] tmds
);

    import dispPkg::*;

    logic [3:0]        dataOnes;
    logic [3:0]        qmOnes;
    logic              useXnor;
    logic [8:0]        qm;
    // ones minus zeros of qm[7:0]
    logic signed [5:0] qmBias;
    // running disparity of the sent words
    logic signed [5:0] dispCnt;
    logic signed [5:0] dispNext;
    logic [9:0]        wordNext;
    logic [9:0]        ctrlWord;

    // --------------------
    // stage 1, transition minimising
    // --------------------
    always_comb begin
        dataOnes = '0;
        for (int i = 0; i < 8; i++) begin
            dataOnes = dataOnes + 4'(data[i]);
        end
        // XNOR when the byte is ones heavy
        useXnor = (dataOnes > 4'd4) || ((dataOnes == 4'd4) && !data[0]);
        qm[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = useXnor ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
        end
        // bit 8 flags XOR chaining
        qm[8] = ~useXnor;
        qmOnes = '0;
        for (int i = 0; i < 8; i++) begin
            qmOnes = qmOnes + 4'(qm[i]);
        end
        qmBias = $signed({1'b0, qmOnes, 1'b0}) - 6'sd8;
    end

    // --------------------
    // stage 2, DC balancing
    // --------------------
    always_comb begin
        if ((dispCnt == 0) || (qmBias == 0)) begin
            // neutral, bit 9 just mirrors the chaining flag
            wordNext = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
            dispNext = qm[8] ? (dispCnt + qmBias) : (dispCnt - qmBias);
        end else if (((dispCnt > 0) && (qmBias > 0)) || ((dispCnt < 0) && (qmBias < 0))) begin
            // invert to pull disparity back to zero
            wordNext = {1'b1, qm[8], ~qm[7:0]};
            dispNext = dispCnt + (qm[8] ? 6'sd2 : 6'sd0) - qmBias;
        end else begin
            wordNext = {1'b0, qm[8], qm[7:0]};
            dispNext = dispCnt - (qm[8] ? 6'sd0 : 6'sd2) + qmBias;
        end
    end

    // blanking token from {c1, c0}
    always_comb begin
        case (ctrl)
            2'b00:   ctrlWord = ctrlTok00;
            2'b01:   ctrlWord = ctrlTok01;
            2'b10:   ctrlWord = ctrlTok10;
            default: ctrlWord = ctrlTok11;
        endcase
    end

    // --------------------
    // output register
    // --------------------
    // control pair is steady during reset, so the reset word is its token
    always_ff @(posedge pixelClk or negedge arstN) begin
        if (!arstN) begin
            tmds    <= ctrlWord;
            dispCnt <= '0;
        end else if (de) begin
            tmds    <= wordNext;
            dispCnt <= dispNext;
        end else begin
            // disparity restarts every blanking period
            tmds    <= ctrlWord;
            dispCnt <= '0;
        end
    end

endmodule

// ==== src/displayTop.sv ====
`timescale 1ns/1ps

module displayTop (
    input  logic       pixelClk,
    input  logic       arstN,
    input  logic       patternSel,
    output logic [9:0] tmds0,
    output logic [9:0] tmds1,
    output logic [9:0] tmds2
);

    import dispPkg::*;

    // counter outputs
    logic [hCountW-1:0] hCount;
    logic [vCountW-1:0] vCount;
    logic               lineEnd;
    logic               frameEnd;

    // timing outputs
    logic               hsync;
    logic               vsync;
    logic               de;
    logic               frameStart;
    logic [hCountW-1:0] xPos;
    logic [vCountW-1:0] yPos;

    // pattern outputs
    pixel_u             pixel;
    logic               pDe;
    logic               pHsync;
    logic               pVsync;

    // --------------------
    // display timing
    // --------------------
    dispCounter uCounter (
        .pixelClk (pixelClk), .arstN    (arstN),
        .hCount   (hCount),   .vCount   (vCount),
        .lineEnd  (lineEnd),  .frameEnd (frameEnd)
    );

    dispTimingFsm uTiming (
        .pixelClk   (pixelClk),   .arstN    (arstN),
        .hCount     (hCount),     .vCount   (vCount),
        .lineEnd    (lineEnd),    .frameEnd (frameEnd),
        .hsync      (hsync),      .vsync    (vsync),
        .de         (de),         .frameStart (frameStart),
        .xPos       (xPos),       .yPos     (yPos)
    );

    // test pattern source
    pixelPattern uPattern (
        .pixelClk   (pixelClk),   .arstN      (arstN),
        .patternSel (patternSel), .frameStart (frameStart),
        .hsync      (hsync),      .vsync      (vsync),
        .de         (de),         .xPos       (xPos),
        .yPos       (yPos),       .pixel      (pixel),
        .pDe        (pDe),        .pHsync     (pHsync),
        .pVsync     (pVsync)
    );

    // --------------------
    // TMDS channels
    // --------------------
    // blue carries the syncs as {vsync, hsync}
    tmdsEncoder uEnc0 (
        .pixelClk (pixelClk), .arstN (arstN), .de (pDe),
        .ctrl ({pVsync, pHsync}), .data (pixel.ch[0]), .tmds (tmds0)
    );

    // green and red send the idle token in blanking
    tmdsEncoder uEnc1 (
        .pixelClk (pixelClk), .arstN (arstN), .de (pDe),
        .ctrl (2'b00), .data (pixel.ch[1]), .tmds (tmds1)
    );

    tmdsEncoder uEnc2 (
        .pixelClk (pixelClk), .arstN (arstN), .de (pDe),
        .ctrl (2'b00), .data (pixel.ch[2]), .tmds (tmds2)
    );

endmodule

// ==== sim/tbRef.svh ====
`ifndef TBREF_SVH
`define TBREF_SVH

// --------------------
// expected picture
// --------------------
// byte on one TMDS channel, ch 0 blue, 1 green, 2 red
function automatic logic [7:0] refChannel(input int x, input int y, input logic pat,
                                          input int ch);
    logic [2:0] rgb;
    logic [7:0] colour [3];
    rgb = 3'b000;
    if (pat == patGradient) begin
        colour[2] = 8'(x);
        colour[1] = 8'(y);
        // sum wraps to one byte
        colour[0] = 8'(x + y);
    end else begin
        // bars left to right, bits are {red, green, blue}
        case (x / barWidth)
            0:       rgb = 3'b111;   // white
            1:       rgb = 3'b110;   // yellow
            2:       rgb = 3'b011;   // cyan
            3:       rgb = 3'b010;   // green
            4:       rgb = 3'b101;   // magenta
            5:       rgb = 3'b100;   // red
            6:       rgb = 3'b001;   // blue
            default: rgb = 3'b000;   // black
        endcase
        colour[2] = {8{rgb[2]}};
        colour[1] = {8{rgb[1]}};
        colour[0] = {8{rgb[0]}};
    end
    return colour[ch];
endfunction

// --------------------
// TMDS word decoding
// --------------------
function automatic logic isCtrlToken(input logic [9:0] w);
    return (w == ctrlTok00) || (w == ctrlTok01) || (w == ctrlTok10) || (w == ctrlTok11);
endfunction

// control pair {c1, c0} carried by a token
function automatic logic [1:0] tokenPair(input logic [9:0] w);
    case (w)
        ctrlTok00: return 2'b00;
        ctrlTok01: return 2'b01;
        ctrlTok10: return 2'b10;
        default:   return 2'b11;
    endcase
endfunction

// bit 9 set means low byte sent inverted, bit 8 set means XOR chain
function automatic logic [7:0] decodeData(input logic [9:0] w);
    logic [7:0] d;
    logic [7:0] b;
    d    = w[9] ? ~w[7:0] : w[7:0];
    b[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        b[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return b;
endfunction

// ones minus zeros over all ten bits
function automatic int wordBias(input logic [9:0] w);
    int ones;
    ones = 0;
    for (int i = 0; i < 10; i++) begin
        ones = ones + int'(w[i]);
    end
    return 2 * ones - 10;
endfunction

`endif

// ==== sim/tbDisplay.sv ====
`timescale 1ns/1ps

module tbDisplay;

    import dispPkg::*;

    `include "tbRef.svh"

    localparam int numFrames    = 4;
    // one frame plus some slack
    localparam int vsyncTimeout = hTotal * vTotal + 2000;
    localparam int balanceLimit = 20;

    logic       pixelClk;
    logic       arstN;
    logic       patternSel;
    logic [9:0] tmds0;
    logic [9:0] tmds1;
    logic [9:0] tmds2;

    // pattern of each frame in arrival order
    logic       patQueue[$];
    logic       seenBars     = 1'b0;
    logic       seenGradient = 1'b0;
    int         timeoutCount = 0;

    // checker state
    int         checkErrors  = 0;
    int         rstCycles    = 0;
    logic       released     = 1'b0;
    logic       curPat       = patBars;
    int         cyc          = 0;
    int         dataX        = 0;
    int         dataY        = 0;
    logic       inData       = 1'b0;
    logic       lineHadData  = 1'b0;
    int         dataEndCyc   = 0;
    int         hsFallCyc    = -1;
    int         vsFallCyc    = -1;
    logic       hsWasAct     = 1'b0;
    logic       vsWasAct     = 1'b0;
    int         vsyncCount   = 0;
    int         balance [3]  = '{0, 0, 0};

    initial pixelClk = 1'b0;
    always #10 pixelClk = ~pixelClk;

    displayTop u_dut (
        .pixelClk   (pixelClk),
        .arstN      (arstN),
        .patternSel (patternSel),
        .tmds0      (tmds0),
        .tmds1      (tmds1),
        .tmds2      (tmds2)
    );

    task automatic showValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        checkErrors++;
    endtask

    // blanking with both syncs inactive
    task automatic checkIdle();
        if (tmds0 !== ctrlTok11) showValue("tmds0 idle token", 32'(ctrlTok11), 32'(tmds0));
        if (tmds1 !== ctrlTok00) showValue("tmds1 idle token", 32'(ctrlTok00), 32'(tmds1));
        if (tmds2 !== ctrlTok00) showValue("tmds2 idle token", 32'(ctrlTok00), 32'(tmds2));
    endtask

    // --------------------
    // per word compare
    // --------------------
    task automatic watchCycle();
        logic [9:0] words [3];
        logic [7:0] got;
        logic [7:0] exp;
        logic       isData;
        logic [1:0] pair;
        logic       hsAct;
        logic       vsAct;
        words[0] = tmds0;
        words[1] = tmds1;
        words[2] = tmds2;
        isData   = !isCtrlToken(words[0]);
        // syncs sit inactive under data words
        pair     = isData ? {~syncActive, ~syncActive} : tokenPair(words[0]);
        hsAct    = (pair[0] == syncActive);
        vsAct    = (pair[1] == syncActive);
        if (isData) begin
            // first word of a frame picks up its pattern
            if (dataX == 0 && dataY == 0) begin
                if (patQueue.size() == 0) begin
                    $display("no pattern recorded for the frame starting at cycle %0d", cyc);
                    checkErrors++;
                end else begin
                    curPat = patQueue.pop_front();
                end
            end
            if (dataX >= hDisplay || dataY >= vDisplay) begin
                $display("data word outside the active area at x=%0d y=%0d", dataX, dataY);
                checkErrors++;
            end else begin
                for (int ch = 0; ch < 3; ch++) begin
                    // channel 0 already decoded as data
                    if (ch > 0 && isCtrlToken(words[ch])) begin
                        $display("tmds%0d sent a control token inside active data", ch);
                        checkErrors++;
                    end
                    got = decodeData(words[ch]);
                    exp = refChannel(dataX, dataY, curPat, ch);
                    if (got !== exp) begin
                        showValue($sformatf("tmds%0d data x=%0d y=%0d", ch, dataX, dataY),
                                  32'(exp), 32'(got));
                    end
                    balance[ch] += wordBias(words[ch]);
                    if (balance[ch] > balanceLimit || balance[ch] < -balanceLimit) begin
                        $display("tmds%0d disparity %0d out of bounds at x=%0d y=%0d",
                                 ch, balance[ch], dataX, dataY);
                        checkErrors++;
                    end
                end
            end
            dataX++;
            inData = 1'b1;
        end else begin
            if (words[1] !== ctrlTok00) showValue("tmds1 token", 32'(ctrlTok00), 32'(words[1]));
            if (words[2] !== ctrlTok00) showValue("tmds2 token", 32'(ctrlTok00), 32'(words[2]));
            if (inData) begin
                // active run just ended
                if (dataX != hDisplay) showValue("data words per line", hDisplay, dataX);
                dataEndCyc  = cyc;
                lineHadData = 1'b1;
                dataY++;
                dataX  = 0;
                inData = 1'b0;
            end
            balance = '{0, 0, 0};
        end
        // horizontal timing off the decoded hsync
        if (hsAct && !hsWasAct) begin
            if (hsFallCyc >= 0 && cyc - hsFallCyc != hTotal) begin
                showValue("hsync period", hTotal, cyc - hsFallCyc);
            end
            if (lineHadData && cyc - dataEndCyc != hFront) begin
                showValue("data end to hsync", hFront, cyc - dataEndCyc);
            end
            hsFallCyc   = cyc;
            lineHadData = 1'b0;
        end
        if (!hsAct && hsWasAct && cyc - hsFallCyc != hSync) begin
            showValue("hsync width", hSync, cyc - hsFallCyc);
        end
        // vertical timing in clocks of whole lines
        if (vsAct && !vsWasAct) begin
            if (vsFallCyc >= 0 && cyc - vsFallCyc != hTotal * vTotal) begin
                showValue("vsync period", hTotal * vTotal, cyc - vsFallCyc);
            end
            if (dataY != vDisplay) showValue("data lines per frame", vDisplay, dataY);
            vsFallCyc = cyc;
            dataY     = 0;
            vsyncCount++;
        end
        if (!vsAct && vsWasAct && cyc - vsFallCyc != vSync * hTotal) begin
            showValue("vsync width", vSync * hTotal, cyc - vsFallCyc);
        end
        hsWasAct = hsAct;
        vsWasAct = vsAct;
        cyc++;
    endtask

    always @(posedge pixelClk) begin
        if (!arstN) begin
            rstCycles++;
            // control pair settles over the first two edges
            if (rstCycles > 2) checkIdle();
        end else begin
            if (!released) begin
                released = 1'b1;
                checkIdle();
            end
            watchCycle();
        end
    end

    // --------------------
    // stimulus
    // --------------------
    // last frame takes whichever pattern has not run yet
    task automatic pickPattern(input int frame);
        logic pat;
        pat = 1'($urandom());
        if (frame == numFrames - 1) begin
            if (!seenBars) begin
                pat = patBars;
            end else if (!seenGradient) begin
                pat = patGradient;
            end
        end
        if (pat == patBars) begin
            seenBars = 1'b1;
        end else begin
            seenGradient = 1'b1;
        end
        patternSel = pat;
        patQueue.push_back(pat);
    endtask

    task automatic waitForVsync(input int target, output logic timedOut);
        int waited;
        waited = 0;
        while (vsyncCount < target && waited < vsyncTimeout) begin
            @(negedge pixelClk);
            waited++;
        end
        timedOut = (vsyncCount < target);
        if (timedOut) begin
            $display("timeout: vsync number %0d did not arrive within %0d cycles",
                     target, vsyncTimeout);
            timeoutCount++;
        end
    endtask

    initial begin
        logic timedOut;
        arstN = 1'b0;
        patternSel = patBars;
        void'($urandom(26173));
        // frame 0 starts right after reset
        pickPattern(0);
        repeat (8) @(posedge pixelClk);
        @(negedge pixelClk);
        arstN = 1'b1;
        timedOut = 1'b0;
        // new pattern during vertical blanking well ahead of the next frame start
        for (int f = 1; f <= numFrames && !timedOut; f++) begin
            waitForVsync(f, timedOut);
            if (!timedOut && f < numFrames) pickPattern(f);
        end
        $display("errors: %0d mismatches, %0d timeouts", checkErrors, timeoutCount);
        if (checkErrors == 0 && timeoutCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
src/dispPkg.sv
src/dispCounter.sv
src/dispTimingFsm.sv
src/pixelPattern.sv
src/tmdsEncoder.sv
src/displayTop.sv
sim/tbDisplay.sv

// ==== Makefile ====
# Verilator build and run of the display testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -f flist.f --top-module tbDisplay -Mdir obj_dir
	./obj_dir/VtbDisplay | tee $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
